// ==== hdl/i2c_rx_pkg.sv ====
// I2C receive front end definitions
package i2c_rx_pkg;

  // number of independent two-wire buses.
  localparam int unsigned NumLanes = 4;

  // synchronizer flops per line.
  localparam int unsigned SyncStages = 2;

  // one received data byte.
  typedef logic [7:0] byte_t;

  // lane number, wide enough for NumLanes.
  typedef logic [$clog2(NumLanes)-1:0] lane_idx_t;

  // one bit per lane.
  typedef logic [NumLanes-1:0] lane_vec_t;

  // per-lane receive flow states.
  typedef enum logic [2:0] {
    Idle,
    ReadByte,
    ReadBit,
    NextTaskDecision
  } rx_state_e;

endpackage

// ==== hdl/rx_result_if.sv ====
// Lane receive result bundle
interface rx_result_if
  import i2c_rx_pkg::*;
();

  byte_t rx_data;  // valid only with rx_done.
  logic  rx_done;  // one-cycle strobe.
  logic  rx_idle;
  logic  error;

  modport flow (
    output rx_data,
    output rx_done,
    output rx_idle,
    output error
  );

  modport collector (
    input rx_data,
    input rx_done,
    input rx_idle,
    input error
  );

endinterface

// ==== hdl/bus_line_sampler.sv ====
// Bus line synchronizer and SCL edge detect
module bus_line_sampler
  import i2c_rx_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  input  lane_vec_t scl_i,
  input  lane_vec_t sda_i,

  output lane_vec_t scl_posedge_o,
  output lane_vec_t scl_stable_high_o,
  output lane_vec_t sda_o
);

  lane_vec_t scl_sync_q [SyncStages];
  lane_vec_t sda_sync_q [SyncStages];

  lane_vec_t scl_sync;
  lane_vec_t sda_sync;

  lane_vec_t scl_hist_q;
  lane_vec_t scl_posedge_q;
  lane_vec_t scl_high_q;
  lane_vec_t sda_q;

  assign scl_sync = scl_sync_q[SyncStages-1];
  assign sda_sync = sda_sync_q[SyncStages-1];

  // both lines idle high on an open-drain bus.
  always_ff @(posedge clk_i or negedge rst_ni) begin : sync_lines
    if (!rst_ni) begin
      for (int s = 0; s < SyncStages; s++) begin
        scl_sync_q[s] <= '1;
        sda_sync_q[s] <= '1;
      end
    end else begin
      scl_sync_q[0] <= scl_i;
      sda_sync_q[0] <= sda_i;
      for (int s = 1; s < SyncStages; s++) begin
        scl_sync_q[s] <= scl_sync_q[s-1];
        sda_sync_q[s] <= sda_sync_q[s-1];
      end
    end
  end

  // edge and level per lane, all registered.
  always_ff @(posedge clk_i or negedge rst_ni) begin : detect_scl
    if (!rst_ni) begin
      scl_hist_q    <= '1;
      scl_posedge_q <= '0;
      scl_high_q    <= '0;
      sda_q         <= '1;
    end else begin
      scl_hist_q    <= scl_sync;
      scl_posedge_q <= scl_sync & ~scl_hist_q;  // low then high.
      scl_high_q    <= scl_sync & scl_hist_q;   // two high samples.
      sda_q         <= sda_sync;                // aligned with the strobe.
    end
  end

  assign scl_posedge_o     = scl_posedge_q;
  assign scl_stable_high_o = scl_high_q;
  assign sda_o             = sda_q;

endmodule

// ==== hdl/bus_rx_flow.sv ====
// Per-lane bit and byte receiver
module bus_rx_flow
  import i2c_rx_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,

  input  logic scl_posedge_i,
  input  logic scl_stable_high_i,
  input  logic sda_i,

  input  logic rx_req_bit_i,
  input  logic rx_req_byte_i,

  rx_result_if.flow res_o
);

  rx_state_e state_d, state_q;

  logic       req;
  logic       req_conflict;
  logic       rx_req_bit_q;

  logic       rx_bit_en;
  logic       rx_bit_q;
  logic       rx_done_q;

  logic       bit_cnt_en;
  logic [2:0] bit_cnt_q;
  logic [6:0] shift_q;
  logic       last_bit;

  byte_t      rx_data;
  logic       rx_done;
  logic       rx_idle;

  assign req          = rx_req_bit_i | rx_req_byte_i;
  assign req_conflict = rx_req_bit_i & rx_req_byte_i;

  // bit request seen one cycle late, byte wins a tie.
  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_bit_req
    if (!rst_ni) begin
      rx_req_bit_q <= 1'b0;
    end else begin
      rx_req_bit_q <= rx_req_bit_i;
    end
  end

  // completion strobe, one cycle after the edge.
  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_rx_done
    if (!rst_ni) begin
      rx_done_q <= 1'b0;
    end else begin
      rx_done_q <= rx_bit_en & scl_posedge_i;
    end
  end

  always_ff @(posedge clk_i) begin : capture_bit
    if (rx_bit_en && scl_posedge_i) begin
      rx_bit_q <= sda_i;
    end
  end

  // seven leading bits, MSB first.
  always_ff @(posedge clk_i) begin : shift_byte
    if (bit_cnt_en && rx_done_q) begin
      shift_q <= {shift_q[5:0], rx_bit_q};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : count_bits
    if (!rst_ni) begin
      bit_cnt_q <= 3'd7;
    end else if (!bit_cnt_en) begin
      bit_cnt_q <= 3'd7;
    end else if (rx_done_q) begin
      bit_cnt_q <= bit_cnt_q - 3'd1;
    end
  end

  // live SDA while SCL is still high, else the edge sample.
  assign last_bit = scl_stable_high_i ? sda_i : rx_bit_q;

  always_comb begin : select_data
    if (state_q == ReadBit) begin
      rx_data = {7'b0, rx_bit_q};
    end else begin
      rx_data = {shift_q, last_bit};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_state
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin : fsm_outputs
    rx_idle    = 1'b0;
    rx_done    = 1'b0;
    rx_bit_en  = 1'b0;
    bit_cnt_en = 1'b0;

    unique case (state_q)
      Idle: begin
        rx_idle = 1'b1;
      end
      ReadByte: begin
        bit_cnt_en = 1'b1;
        rx_bit_en  = ~rx_done_q;
        rx_done    = rx_done_q & (bit_cnt_q == 3'd0);  // eighth bit.
      end
      ReadBit: begin
        rx_bit_en = ~rx_done_q;
        rx_done   = rx_done_q;
      end
      NextTaskDecision: begin
        rx_bit_en = req;  // don't miss an early edge.
      end
      default: ;
    endcase
  end

  always_comb begin : fsm_next
    state_d = state_q;

    unique case (state_q)
      Idle, NextTaskDecision: begin
        if (rx_req_byte_i) begin
          state_d = ReadByte;
        end else if (rx_req_bit_q) begin
          state_d = ReadBit;
        end else begin
          state_d = Idle;
        end
      end
      ReadByte: begin
        if (rx_done) state_d = NextTaskDecision;
      end
      ReadBit: begin
        if (rx_done_q) state_d = NextTaskDecision;
      end
      default: begin
        state_d = Idle;
      end
    endcase

    // abort or conflict.
    if (!req || req_conflict) begin
      state_d = Idle;
    end
  end

  assign res_o.rx_data = rx_data;
  assign res_o.rx_done = rx_done;
  assign res_o.rx_idle = rx_idle;
  assign res_o.error   = req_conflict;

endmodule

// ==== hdl/rx_byte_collector.sv ====
// Round-robin result collector
module rx_byte_collector
  import i2c_rx_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  rx_result_if.collector res_i [NumLanes],

  output logic      out_valid_o,
  output lane_idx_t out_lane_o,
  output byte_t     out_data_o,
  output lane_vec_t rx_idle_o,
  output lane_vec_t error_o
);

  lane_vec_t done_vec;
  byte_t     data_vec [NumLanes];

  lane_vec_t full_q;
  byte_t     hold_q [NumLanes];
  lane_idx_t last_q;

  logic      grant_valid;
  lane_idx_t grant_lane;
  lane_vec_t issue_vec;

  // flatten the interface array.
  for (genvar i = 0; i < NumLanes; i++) begin : g_lane
    assign done_vec[i]  = res_i[i].rx_done;
    assign data_vec[i]  = res_i[i].rx_data;
    assign rx_idle_o[i] = res_i[i].rx_idle;
    assign error_o[i]   = res_i[i].error;
  end

  // first full lane after the last one served.
  always_comb begin : pick_next
    lane_idx_t cand;

    grant_valid = 1'b0;
    grant_lane  = last_q;
    for (int k = 1; k <= NumLanes; k++) begin
      cand = lane_idx_t'((int'(last_q) + k) % NumLanes);
      if (!grant_valid && full_q[cand]) begin
        grant_valid = 1'b1;
        grant_lane  = cand;
      end
    end
  end

  assign issue_vec = lane_vec_t'(grant_valid) << grant_lane;

  // new result wins over the one leaving.
  always_ff @(posedge clk_i or negedge rst_ni) begin : track_full
    if (!rst_ni) begin
      full_q <= '0;
      last_q <= lane_idx_t'(NumLanes - 1);  // lane 0 goes first.
    end else begin
      full_q <= (full_q & ~issue_vec) | done_vec;
      if (grant_valid) begin
        last_q <= grant_lane;
      end
    end
  end

  always_ff @(posedge clk_i) begin : hold_data
    for (int i = 0; i < NumLanes; i++) begin
      if (done_vec[i]) begin
        hold_q[i] <= data_vec[i];
      end
    end
  end

  assign out_valid_o = grant_valid;
  assign out_lane_o  = grant_lane;
  assign out_data_o  = hold_q[grant_lane];

endmodule

// ==== hdl/i2c_rx_top.sv ====
// Four-lane I2C receive front end
module i2c_rx_top
  import i2c_rx_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  input  lane_vec_t scl_i,
  input  lane_vec_t sda_i,
  input  lane_vec_t rx_req_bit_i,
  input  lane_vec_t rx_req_byte_i,

  output logic      out_valid_o,
  output lane_idx_t out_lane_o,
  output byte_t     out_data_o,
  output lane_vec_t rx_idle_o,
  output lane_vec_t error_o
);

  lane_vec_t scl_posedge;
  lane_vec_t scl_stable_high;
  lane_vec_t sda_sync;

  rx_result_if res_if [NumLanes] ();

  bus_line_sampler u_sampler (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .scl_i             (scl_i),
    .sda_i             (sda_i),
    .scl_posedge_o     (scl_posedge),
    .scl_stable_high_o (scl_stable_high),
    .sda_o             (sda_sync)
  );

  // one receive flow per lane.
  for (genvar i = 0; i < NumLanes; i++) begin : u_flow
    bus_rx_flow u_bus_rx_flow (
      .clk_i             (clk_i),
      .rst_ni            (rst_ni),
      .scl_posedge_i     (scl_posedge[i]),
      .scl_stable_high_i (scl_stable_high[i]),
      .sda_i             (sda_sync[i]),
      .rx_req_bit_i      (rx_req_bit_i[i]),
      .rx_req_byte_i     (rx_req_byte_i[i]),
      .res_o             (res_if[i])
    );
  end

  rx_byte_collector u_collector (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .res_i       (res_if),
    .out_valid_o (out_valid_o),
    .out_lane_o  (out_lane_o),
    .out_data_o  (out_data_o),
    .rx_idle_o   (rx_idle_o),
    .error_o     (error_o)
  );

endmodule

// ==== test/i2c_lane_driver.sv ====
// Two-wire lane bus model
module i2c_lane_driver (
  input  logic clk_i,
  output logic scl_o,
  output logic sda_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned LowClocks  = 6;
  localparam int unsigned HighClocks = 6;

  // SCL parked low so reset sees no edge.
  initial begin
    scl_o = 1'b0;
    sda_o = 1'b1;
  end

  // sends bits[count-1] down to bits[0].
  task automatic send_bits(input logic [7:0] bits, input int unsigned count);
    for (int i = int'(count) - 1; i >= 0; i--) begin
      @(posedge clk_i);
      sda_o <= bits[i];  // data moves while SCL is low.
      repeat (LowClocks) @(posedge clk_i);
      scl_o <= 1'b1;
      repeat (HighClocks) @(posedge clk_i);
      scl_o <= 1'b0;
    end
  endtask

endmodule

// ==== test/tb_i2c_rx_top.sv ====
// Four-lane receiver testbench
module tb_i2c_rx_top
  import i2c_rx_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned ClkPeriod    = 4;
  localparam int unsigned NumTransfers = 25;
  localparam int unsigned MarginCycles = 400 + 10 * SyncStages;
  localparam int unsigned TimeoutNs    = (NumTransfers * 9 * 12 + MarginCycles) * ClkPeriod;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  wire       lane_vec_t scl;
  wire       lane_vec_t sda;
  lane_vec_t req_bit;
  lane_vec_t req_byte;
  logic      out_valid;
  lane_idx_t out_lane;
  byte_t     out_data;
  lane_vec_t rx_idle;
  lane_vec_t error;

  byte_t       exp_q [NumLanes][$];
  byte_t       cc_data [NumLanes][3];
  int unsigned cc_offset [NumLanes];
  int unsigned errors = 0;
  int unsigned missing = 0;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  i2c_rx_top u_i2c_rx_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .scl_i         (scl),
    .sda_i         (sda),
    .rx_req_bit_i  (req_bit),
    .rx_req_byte_i (req_byte),
    .out_valid_o   (out_valid),
    .out_lane_o    (out_lane),
    .out_data_o    (out_data),
    .rx_idle_o     (rx_idle),
    .error_o       (error)
  );

  i2c_lane_driver u_drv0 (.clk_i(clk_i), .scl_o(scl[0]), .sda_o(sda[0]));
  i2c_lane_driver u_drv1 (.clk_i(clk_i), .scl_o(scl[1]), .sda_o(sda[1]));
  i2c_lane_driver u_drv2 (.clk_i(clk_i), .scl_o(scl[2]), .sda_o(sda[2]));
  i2c_lane_driver u_drv3 (.clk_i(clk_i), .scl_o(scl[3]), .sda_o(sda[3]));

  // bits packed MSB first, or one bit in bit 0.
  function automatic byte_t expected_result(input byte_t bits, input int unsigned count,
                                            input bit is_byte);
    byte_t value;
    value = '0;
    for (int i = int'(count) - 1; i >= 0; i--) begin
      value = {value[6:0], bits[i]};
    end
    if (!is_byte) begin
      value = {7'b0, value[0]};
    end
    return value;
  endfunction

  task automatic send_on_lane(input int lane, input byte_t bits, input int unsigned count);
    case (lane)
      0: u_drv0.send_bits(bits, count);
      1: u_drv1.send_bits(bits, count);
      2: u_drv2.send_bits(bits, count);
      default: u_drv3.send_bits(bits, count);
    endcase
  endtask

  task automatic set_req(input int lane, input logic bit_lvl, input logic byte_lvl);
    @(posedge clk_i);
    req_bit[lane]  <= bit_lvl;
    req_byte[lane] <= byte_lvl;
  endtask

  task automatic check_level(input string name, input lane_vec_t got, input lane_vec_t want);
    assert (got === want) else begin
      $display("[ERROR] %s = %h, expected %h", name, got, want);
      errors++;
    end
  endtask

  // request held across all bytes given.
  task automatic receive_bytes(input int lane, input byte_t data [], input int unsigned gap);
    repeat (gap) @(posedge clk_i);
    set_req(lane, 1'b0, 1'b1);
    repeat (2) @(posedge clk_i);
    foreach (data[k]) begin
      exp_q[lane].push_back(expected_result(data[k], 8, 1'b1));
      send_on_lane(lane, data[k], 8);
    end
    set_req(lane, 1'b0, 1'b0);
  endtask

  always @(negedge clk_i) begin : check_output
    byte_t want;
    if (rst_ni && out_valid) begin
      assert (exp_q[out_lane].size() > 0) else begin
        $display("unexpected result 0x%h on lane %0d", out_data, out_lane);
        errors++;
      end
      if (exp_q[out_lane].size() > 0) begin
        want = exp_q[out_lane].pop_front();
        assert (out_data === want) else begin
          $display("[ERROR] out_data_o = %h, expected %h (lane %0d)", out_data, want, out_lane);
          errors++;
        end
      end
    end
  end

  initial begin : watchdog
    #(TimeoutNs);
    $display("timeout: transfers did not finish in %0d ns", TimeoutNs);
    $display("errors: %0d, missing: %0d", errors, missing);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    byte_t one [];
    byte_t bits;
    rst_ni   = 1'b0;
    req_bit  = '0;
    req_byte = '0;
    void'($urandom(32'h09c1c716));
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (4) @(posedge clk_i);

    // all lanes idle and clean out of reset.
    @(negedge clk_i);
    check_level("rx_idle_o", rx_idle, '1);
    check_level("error_o", error, '0);

    // single bytes on random lanes.
    one = new[1];
    repeat (4) begin
      one[0] = byte_t'($urandom);
      receive_bytes(int'($urandom_range(NumLanes - 1, 0)), one, 0);
      repeat (8) @(posedge clk_i);
    end

    // single bits on lane 0.
    repeat (4) begin
      bits = byte_t'($urandom);
      set_req(0, 1'b1, 1'b0);
      repeat (3) @(posedge clk_i);
      exp_q[0].push_back(expected_result(bits, 1, 1'b0));
      send_on_lane(0, bits, 1);
      set_req(0, 1'b0, 1'b0);
      repeat (8) @(posedge clk_i);
    end

    // all lanes at once, offsets picked up front.
    foreach (cc_data[l, k]) cc_data[l][k] = byte_t'($urandom);
    foreach (cc_offset[l]) cc_offset[l] = $urandom_range(20, 0);
    fork
      receive_bytes(0, cc_data[0], cc_offset[0]);
      receive_bytes(1, cc_data[1], cc_offset[1]);
      receive_bytes(2, cc_data[2], cc_offset[2]);
      receive_bytes(3, cc_data[3], cc_offset[3]);
    join
    repeat (8) @(posedge clk_i);

    // both requests on lane 1.
    set_req(1, 1'b1, 1'b1);
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_level("error_o[1]", error[1], 1'b1);
    send_on_lane(1, byte_t'($urandom), 8);
    @(negedge clk_i);
    check_level("error_o[1]", error[1], 1'b1);
    set_req(1, 1'b0, 1'b0);
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_level("rx_idle_o[1]", rx_idle[1], 1'b1);
    check_level("error_o[1]", error[1], 1'b0);

    // abort after three bits, then a full byte.
    set_req(2, 1'b0, 1'b1);
    repeat (2) @(posedge clk_i);
    send_on_lane(2, byte_t'($urandom), 3);
    set_req(2, 1'b0, 1'b0);
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_level("rx_idle_o[2]", rx_idle[2], 1'b1);
    one[0] = byte_t'($urandom);
    receive_bytes(2, one, 4);
    repeat (8) @(posedge clk_i);

    // two bytes under one held request.
    one = new[2];
    one[0] = byte_t'($urandom);
    one[1] = byte_t'($urandom);
    receive_bytes(3, one, 0);

    for (int n = 0; n < 4 * NumLanes; n++) begin
      @(posedge clk_i);
    end
    foreach (exp_q[l]) missing += exp_q[l].size();
    $display("errors: %0d, missing: %0d", errors, missing);
    if (errors == 0 && missing == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
hdl/i2c_rx_pkg.sv
hdl/rx_result_if.sv
hdl/bus_line_sampler.sv
hdl/bus_rx_flow.sv
hdl/rx_byte_collector.sv
hdl/i2c_rx_top.sv
test/i2c_lane_driver.sv
test/tb_i2c_rx_top.sv
